// File: hw/bus_share_pkg.sv
// Shared bus field types and defaults; MEM_WORDS must be a power of two no larger than 2**19
package bus_share_pkg;

    // Word address, byte address bit 0 is implied by bytesel
    typedef logic [19:1] addr_t;

    // One bus data word
    typedef logic [15:0] data_t;

    // Byte lanes
    // bit 0 selects data[7:0], bit 1 selects data[15:8]
    typedef logic [1:0] bytesel_t;

    // Arbiter states
    // Release is the single cycle in which the registered master ack is high
    typedef enum logic [1:0] {
        GRANT_IDLE    = 2'd0,
        GRANT_BUSY    = 2'd1,
        GRANT_RELEASE = 2'd2
    } grant_state_t;

    // Wait states before every memory ack
    localparam int DEF_WAIT_STATES = 2;

    // Memory depth in 16-bit words, addresses wrap at this size
    localparam int DEF_MEM_WORDS = 1024;

endpackage

// File: hw/mem_bus_if.sv
// One word-wide memory bus; fields are held stable by the master until its one-cycle ack
`timescale 1ns/1ps

interface mem_bus_if
    import bus_share_pkg::*;
();

    // Request fields, owned by the master
    addr_t    addr;
    data_t    wdata;
    logic     access;
    logic     wr_en;
    bytesel_t bytesel;

    // Response, owned by the slave
    // rdata is only meaningful while ack is high
    data_t    rdata;
    logic     ack;

    modport master (
        output addr,
        output wdata,
        output access,
        output wr_en,
        output bytesel,
        input  rdata,
        input  ack
    );

    modport slave (
        input  addr,
        input  wdata,
        input  access,
        input  wr_en,
        input  bytesel,
        output rdata,
        output ack
    );

endinterface

// File: hw/grant_fsm.sv
// Two-master arbiter FSM; data bus (b) wins a tie, one transfer at a time, one release cycle per ack
`timescale 1ns/1ps

module grant_fsm
    import bus_share_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic a_access,
    input  logic b_access,
    input  logic mem_ack,
    output logic grant_to_b,
    output logic grant_active
);

    grant_state_t state;

    // Master chosen when the transfer started
    logic b_latched;

    // Fixed priority, data bus first
    logic b_wins;

    assign b_wins = b_access;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= GRANT_IDLE;
            b_latched <= 1'b0;
        end else begin
            case (state)
                GRANT_IDLE: begin
                    if (a_access || b_access) begin
                        b_latched <= b_wins;
                        state     <= GRANT_BUSY;
                    end
                end
                GRANT_BUSY: begin
                    // Memory has finished, hold off one cycle
                    if (mem_ack) begin
                        state <= GRANT_RELEASE;
                    end
                end
                GRANT_RELEASE: begin
                    // Master still shows access here, ignore it
                    state <= GRANT_IDLE;
                end
                default: begin
                    state <= GRANT_IDLE;
                end
            endcase
        end
    end

    // In idle the memory side already follows the priority choice
    always_comb begin
        if (state == GRANT_IDLE) begin
            grant_to_b = b_wins;
        end else begin
            grant_to_b = b_latched;
        end
    end

    assign grant_active = (state == GRANT_BUSY);

endmodule

// File: hw/wait_timer.sv
// Wait-state counter; expired is seen at the WAIT_STATES-th edge after start, never for zero waits
`timescale 1ns/1ps

module wait_timer #(
    parameter int WAIT_STATES = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic expired,
    output logic running
);

    // Counter only needs to hold WAIT_STATES - 1
    localparam int CNT_W = (WAIT_STATES > 2) ? $clog2(WAIT_STATES) : 1;
    localparam int LOAD  = (WAIT_STATES > 0) ? WAIT_STATES - 1 : 0;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            running <= 1'b0;
        end else if (start) begin
            count   <= CNT_W'(LOAD);
            // Zero wait states never run, the controller acks by itself
            running <= (WAIT_STATES > 0);
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // High for the single cycle spent at zero
    assign expired = running && (count == '0);

endmodule

// File: hw/bus_route.sv
// Steers the granted master onto the memory bus; master ack and rdata are one cycle behind memory
`timescale 1ns/1ps

module bus_route
    import bus_share_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic grant_to_b,
    input  logic grant_active,
    mem_bus_if.slave  bus_a,
    mem_bus_if.slave  bus_b,
    mem_bus_if.master bus_q
);

    // Registered per-master acks
    logic a_ack_q;
    logic b_ack_q;

    // Read word from the last memory ack
    data_t rdata_q;

    // Access level of whichever master is selected
    logic sel_access;

    // Any registered ack marks the release cycle
    logic ack_pending;

    // Request fields follow the grant
    assign bus_q.addr    = grant_to_b ? bus_b.addr    : bus_a.addr;
    assign bus_q.wdata   = grant_to_b ? bus_b.wdata   : bus_a.wdata;
    assign bus_q.wr_en   = grant_to_b ? bus_b.wr_en   : bus_a.wr_en;
    assign bus_q.bytesel = grant_to_b ? bus_b.bytesel : bus_a.bytesel;

    assign sel_access  = grant_to_b ? bus_b.access : bus_a.access;
    assign ack_pending = a_ack_q || b_ack_q;

    // No access while memory acks or while the arbiter releases,
    // otherwise the same master would be served twice
    assign bus_q.access = sel_access && !bus_q.ack && !ack_pending;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_ack_q <= 1'b0;
            b_ack_q <= 1'b0;
        end else begin
            a_ack_q <= bus_q.ack && grant_active && !grant_to_b;
            b_ack_q <= bus_q.ack && grant_active && grant_to_b;
        end
    end

    // Read word follows the memory ack
    always_ff @(posedge clk) begin
        if (bus_q.ack) begin
            rdata_q <= bus_q.rdata;
        end
    end

    assign bus_a.ack = a_ack_q;
    assign bus_b.ack = b_ack_q;

    // Unserved master sees zero
    assign bus_a.rdata = a_ack_q ? rdata_q : '0;
    assign bus_b.rdata = b_ack_q ? rdata_q : '0;

endmodule

// File: hw/sram_ctrl.sv
// Word memory with byte lanes, no reset of contents; MEM_WORDS power of two, addresses wrap
`timescale 1ns/1ps

module sram_ctrl
    import bus_share_pkg::*;
#(
    parameter int WAIT_STATES = 2,
    parameter int MEM_WORDS   = 1024
) (
    input  logic clk,
    input  logic reset,
    mem_bus_if.slave bus_q,
    output logic start,
    input  logic expired,
    input  logic running
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t mem [MEM_WORDS];

    // Word index, upper address bits are dropped
    logic [IDX_W-1:0] idx;

    // Cycle in which the transfer actually happens
    logic fire;

    logic  ack_q;
    data_t rdata_q;

    assign idx = bus_q.addr[IDX_W:1];

    // New access kicks off the wait-state timer
    assign start = bus_q.access && !running;

    // Without wait states the timer never runs, so act on start itself
    assign fire = (WAIT_STATES == 0) ? start : expired;

    // Storage and read capture
    always_ff @(posedge clk) begin
        if (fire) begin
            if (bus_q.wr_en) begin
                if (bus_q.bytesel[0]) begin
                    mem[idx][7:0] <= bus_q.wdata[7:0];
                end
                if (bus_q.bytesel[1]) begin
                    mem[idx][15:8] <= bus_q.wdata[15:8];
                end
                // Writes return nothing
                rdata_q <= '0;
            end else begin
                // Reads always fetch the full word
                rdata_q <= mem[idx];
            end
        end
    end

    // One-cycle ack after the transfer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= fire;
        end
    end

    assign bus_q.ack   = ack_q;
    assign bus_q.rdata = rdata_q;

endmodule

// File: hw/bus_share_top.sv
// Two masters share one word memory; access to ack is WAIT_STATES+2 cycles for an uncontended request
`timescale 1ns/1ps

module bus_share_top
    import bus_share_pkg::*;
#(
    parameter int WAIT_STATES = DEF_WAIT_STATES,
    parameter int MEM_WORDS   = DEF_MEM_WORDS
) (
    input  logic     clk,
    input  logic     reset,

    // Instruction bus
    input  addr_t    a_addr,
    input  data_t    a_wdata,
    output data_t    a_rdata,
    input  logic     a_access,
    input  logic     a_wr_en,
    input  bytesel_t a_bytesel,
    output logic     a_ack,

    // Data bus
    input  addr_t    b_addr,
    input  data_t    b_wdata,
    output data_t    b_rdata,
    input  logic     b_access,
    input  logic     b_wr_en,
    input  bytesel_t b_bytesel,
    output logic     b_ack,

    // High while the memory side serves the data bus
    output logic     q_b
);

    mem_bus_if bus_a ();
    mem_bus_if bus_b ();
    mem_bus_if bus_q ();

    logic grant_to_b;
    logic grant_active;
    logic tmr_start;
    logic tmr_expired;
    logic tmr_running;

    // Instruction bus onto its interface
    assign bus_a.addr    = a_addr;
    assign bus_a.wdata   = a_wdata;
    assign bus_a.access  = a_access;
    assign bus_a.wr_en   = a_wr_en;
    assign bus_a.bytesel = a_bytesel;
    assign a_rdata       = bus_a.rdata;
    assign a_ack         = bus_a.ack;

    // Data bus onto its interface
    assign bus_b.addr    = b_addr;
    assign bus_b.wdata   = b_wdata;
    assign bus_b.access  = b_access;
    assign bus_b.wr_en   = b_wr_en;
    assign bus_b.bytesel = b_bytesel;
    assign b_rdata       = bus_b.rdata;
    assign b_ack         = bus_b.ack;

    assign q_b = grant_to_b;

    grant_fsm u_grant_fsm (
        .clk          (clk),
        .reset        (reset),
        .a_access     (a_access),
        .b_access     (b_access),
        .mem_ack      (bus_q.ack),
        .grant_to_b   (grant_to_b),
        .grant_active (grant_active)
    );

    bus_route u_bus_route (
        .clk          (clk),
        .reset        (reset),
        .grant_to_b   (grant_to_b),
        .grant_active (grant_active),
        .bus_a        (bus_a.slave),
        .bus_b        (bus_b.slave),
        .bus_q        (bus_q.master)
    );

    sram_ctrl #(
        .WAIT_STATES (WAIT_STATES),
        .MEM_WORDS   (MEM_WORDS)
    ) u_sram_ctrl (
        .clk     (clk),
        .reset   (reset),
        .bus_q   (bus_q.slave),
        .start   (tmr_start),
        .expired (tmr_expired),
        .running (tmr_running)
    );

    wait_timer #(
        .WAIT_STATES (WAIT_STATES)
    ) u_wait_timer (
        .clk     (clk),
        .reset   (reset),
        .start   (tmr_start),
        .expired (tmr_expired),
        .running (tmr_running)
    );

endmodule

// File: testbench/tb_clock.sv
// Free-running clock and power-on reset; reset falls a few ns after the last reset edge
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // Release away from the clock edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;
    end

endmodule

// File: testbench/bus_share_tb.sv
// Directed tests at W=2 and 1024 words; reads only target words the model has fully written
`timescale 1ns/1ps

module bus_share_tb
    import bus_share_pkg::*;
();

    localparam int W              = DEF_WAIT_STATES;
    localparam int MEM_WORDS      = DEF_MEM_WORDS;
    localparam int IDX_W          = $clog2(MEM_WORDS);
    localparam int DRIVE_DLY      = 5;
    // Lone request acks W+2 cycles after it is sampled, the loser of a tie at 2W+5
    localparam int LONE_CYCLES    = W + 2;
    localparam int SECOND_CYCLES  = 2 * W + 5;
    // Whole run is roughly 350 cycles, limit leaves wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic     clk;
    logic     reset;
    addr_t    a_addr;
    data_t    a_wdata;
    data_t    a_rdata;
    logic     a_access;
    logic     a_wr_en;
    bytesel_t a_bytesel;
    logic     a_ack;
    addr_t    b_addr;
    data_t    b_wdata;
    data_t    b_rdata;
    logic     b_access;
    logic     b_wr_en;
    bytesel_t b_bytesel;
    logic     b_ack;
    logic     q_b;

    // Shadow memory and per-word written flag
    data_t shadow [MEM_WORDS];
    logic  known  [MEM_WORDS];

    // Results of the last transfer
    data_t got_rdata;
    data_t got_other_rdata;
    logic  got_other_ack;
    int    got_cycles;

    // Results of the last simultaneous pair
    data_t pair_a_rdata;
    data_t pair_b_rdata;
    int    pair_a_cycles;
    int    pair_b_cycles;
    logic  pair_q_b;

    string  test_name;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;
    integer seed;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (8)
    ) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    bus_share_top #(
        .WAIT_STATES (W),
        .MEM_WORDS   (MEM_WORDS)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .a_addr    (a_addr),
        .a_wdata   (a_wdata),
        .a_rdata   (a_rdata),
        .a_access  (a_access),
        .a_wr_en   (a_wr_en),
        .a_bytesel (a_bytesel),
        .a_ack     (a_ack),
        .b_addr    (b_addr),
        .b_wdata   (b_wdata),
        .b_rdata   (b_rdata),
        .b_access  (b_access),
        .b_wr_en   (b_wr_en),
        .b_bytesel (b_bytesel),
        .b_ack     (b_ack),
        .q_b       (q_b)
    );

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_data(input string what, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %b actual %b", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic check_cycles(input string what, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", test_name, test_errors);
        end
    endtask

    // Byte lane rule, bit 0 low byte and bit 1 high byte
    function automatic data_t merge_lanes(input data_t old_word, input data_t wdata,
                                          input bytesel_t bsel);
        data_t result;
        result = old_word;
        if (bsel[0]) begin
            result[7:0] = wdata[7:0];
        end
        if (bsel[1]) begin
            result[15:8] = wdata[15:8];
        end
        return result;
    endfunction

    // Addresses wrap modulo the memory depth
    function automatic logic [IDX_W-1:0] word_index(input addr_t addr);
        return addr[IDX_W:1];
    endfunction

    task automatic drive_master(input logic to_b, input addr_t addr, input data_t wdata,
                                input logic wr, input bytesel_t bsel);
        if (to_b) begin
            b_addr    = addr;
            b_wdata   = wdata;
            b_wr_en   = wr;
            b_bytesel = bsel;
            b_access  = 1'b1;
        end else begin
            a_addr    = addr;
            a_wdata   = wdata;
            a_wr_en   = wr;
            a_bytesel = bsel;
            a_access  = 1'b1;
        end
    endtask

    // One request on one bus, held until its ack is seen
    task automatic transfer(input logic to_b, input addr_t addr, input data_t wdata,
                            input logic wr, input bytesel_t bsel);
        int   cycles;
        logic seen;
        @(posedge clk);
        #DRIVE_DLY;
        drive_master(to_b, addr, wdata, wr, bsel);
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            seen = to_b ? b_ack : a_ack;
        end
        got_cycles      = cycles;
        got_rdata       = to_b ? b_rdata : a_rdata;
        got_other_rdata = to_b ? a_rdata : b_rdata;
        got_other_ack   = to_b ? a_ack : b_ack;
        // Hold through the ack edge, then let go
        @(posedge clk);
        #DRIVE_DLY;
        if (to_b) begin
            b_access = 1'b0;
        end else begin
            a_access = 1'b0;
        end
    endtask

    task automatic write_word(input logic to_b, input addr_t addr, input data_t wdata,
                              input bytesel_t bsel);
        transfer(to_b, addr, wdata, 1'b1, bsel);
        shadow[word_index(addr)] = merge_lanes(shadow[word_index(addr)], wdata, bsel);
        if (bsel == 2'b11) begin
            known[word_index(addr)] = 1'b1;
        end
    endtask

    task automatic read_check(input string what, input logic to_b, input addr_t addr);
        transfer(to_b, addr, 16'h0000, 1'b0, 2'b11);
        check_data(what, shadow[word_index(addr)], got_rdata);
    endtask

    // Both masters raise access in the same cycle with full-word transfers
    task automatic pair_transfer(input logic wr_a, input addr_t addr_a, input data_t wdata_a,
                                 input logic wr_b, input addr_t addr_b, input data_t wdata_b);
        int   cycles;
        logic a_seen;
        logic b_seen;
        @(posedge clk);
        #DRIVE_DLY;
        drive_master(1'b0, addr_a, wdata_a, wr_a, 2'b11);
        drive_master(1'b1, addr_b, wdata_b, wr_b, 2'b11);
        cycles   = 0;
        a_seen   = 1'b0;
        b_seen   = 1'b0;
        pair_q_b = 1'b0;
        while (!(a_seen && b_seen)) begin
            @(posedge clk);
            cycles++;
            #DRIVE_DLY;
            // Each master lets go in the cycle after its own ack
            if (a_seen) begin
                a_access = 1'b0;
            end
            if (b_seen) begin
                b_access = 1'b0;
            end
            @(negedge clk);
            if (cycles == 1) begin
                pair_q_b = q_b;
            end
            if (!b_seen && b_ack) begin
                b_seen        = 1'b1;
                pair_b_cycles = cycles;
                pair_b_rdata  = b_rdata;
            end
            if (!a_seen && a_ack) begin
                a_seen        = 1'b1;
                pair_a_cycles = cycles;
                pair_a_rdata  = a_rdata;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        a_access = 1'b0;
        b_access = 1'b0;
        if (wr_a) begin
            shadow[word_index(addr_a)] = wdata_a;
            known[word_index(addr_a)]  = 1'b1;
        end
        if (wr_b) begin
            shadow[word_index(addr_b)] = wdata_b;
            known[word_index(addr_b)]  = 1'b1;
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        @(negedge clk);
        check_bit("a_ack", 1'b0, a_ack);
        check_bit("b_ack", 1'b0, b_ack);
        check_bit("q_b", 1'b0, q_b);
        finish_test();
    endtask

    task automatic test_a_write_read();
        start_test("a_write_read");
        write_word(1'b0, 19'h00012, 16'hA5C3, 2'b11);
        read_check("a read", 1'b0, 19'h00012);
        check_data("a read literal", 16'hA5C3, got_rdata);
        // Idle data bus sees nothing of a's ack
        check_data("b_rdata", 16'h0000, got_other_rdata);
        check_bit("b_ack", 1'b0, got_other_ack);
        finish_test();
    endtask

    task automatic test_b_byte_lanes();
        start_test("b_byte_lanes");
        write_word(1'b1, 19'h00040, 16'h1234, 2'b11);
        write_word(1'b1, 19'h00040, 16'hFFAB, 2'b01);
        write_word(1'b1, 19'h00040, 16'hCD00, 2'b10);
        read_check("b read", 1'b1, 19'h00040);
        check_data("b merged", 16'hCDAB, got_rdata);
        read_check("a read", 1'b0, 19'h00040);
        check_data("a merged", 16'hCDAB, got_rdata);
        finish_test();
    endtask

    task automatic test_simultaneous();
        start_test("simultaneous");
        pair_transfer(1'b1, 19'h00100, 16'h5A01, 1'b1, 19'h00101, 16'hB702);
        check_bit("b acks first", 1'b1, pair_b_cycles < pair_a_cycles);
        check_bit("q_b at grant", 1'b1, pair_q_b);
        // Cross reads of each other's words
        pair_transfer(1'b0, 19'h00101, 16'h0000, 1'b0, 19'h00100, 16'h0000);
        check_bit("b acks first on read", 1'b1, pair_b_cycles < pair_a_cycles);
        check_data("a read", shadow[word_index(19'h00101)], pair_a_rdata);
        check_data("b read", shadow[word_index(19'h00100)], pair_b_rdata);
        finish_test();
    endtask

    task automatic test_latency();
        start_test("latency");
        transfer(1'b0, 19'h00012, 16'h0000, 1'b0, 2'b11);
        check_cycles("lone a", LONE_CYCLES, got_cycles);
        transfer(1'b1, 19'h00040, 16'h0000, 1'b0, 2'b11);
        check_cycles("lone b", LONE_CYCLES, got_cycles);
        pair_transfer(1'b0, 19'h00012, 16'h0000, 1'b0, 19'h00040, 16'h0000);
        check_cycles("pair first", LONE_CYCLES, pair_b_cycles);
        check_cycles("pair second", SECOND_CYCLES, pair_a_cycles);
        finish_test();
    endtask

    task automatic test_random();
        logic [31:0]      rnd;
        logic             to_b;
        logic             wr;
        bytesel_t         bsel;
        addr_t            addr;
        logic [IDX_W-1:0] idx;
        start_test("random");
        for (int i = 0; i < 40; i++) begin
            rnd             = $random(seed);
            to_b            = rnd[0];
            wr              = rnd[1];
            bsel            = rnd[3:2];
            addr            = '0;
            addr[IDX_W:1]   = rnd[IDX_W+3:4];
            idx             = word_index(addr);
            // Unwritten word gets a full write first
            if (!known[idx]) begin
                wr   = 1'b1;
                bsel = 2'b11;
            end
            if (wr) begin
                write_word(to_b, addr, rnd[31:16], bsel);
            end else begin
                read_check("read", to_b, addr);
            end
            check_data("other rdata", 16'h0000, got_other_rdata);
            check_bit("other ack", 1'b0, got_other_ack);
        end
        finish_test();
    endtask

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests still running after %0d cycles", cycle_count);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed         = 37335;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        a_addr       = '0;
        a_wdata      = '0;
        a_access     = 1'b0;
        a_wr_en      = 1'b0;
        a_bytesel    = 2'b00;
        b_addr       = '0;
        b_wdata      = '0;
        b_access     = 1'b0;
        b_wr_en      = 1'b0;
        b_bytesel    = 2'b00;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
            known[i]  = 1'b0;
        end
        wait (reset == 1'b0);
        test_reset();
        test_a_write_read();
        test_b_byte_lanes();
        test_simultaneous();
        test_latency();
        test_random();
        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: bus_share.f
hw/bus_share_pkg.sv
hw/mem_bus_if.sv
hw/grant_fsm.sv
hw/wait_timer.sv
hw/bus_route.sv
hw/sram_ctrl.sv
hw/bus_share_top.sv
testbench/tb_clock.sv
testbench/bus_share_tb.sv

// File: Makefile
# Verilator flow for bus_share; override any variable on the command line

VERILATOR ?= verilator
TOP       ?= bus_share_tb
RTL_TOP   ?= bus_share_top
FILELIST  ?= bus_share.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
